/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tbMipsDecode
FILELIST = mipsDecode.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* include/mipsDecode_cfg.svh */
`ifndef MIPS_DECODE_CFG_SVH
`define MIPS_DECODE_CFG_SVH

// ############################################################
// core sizing.
// ############################################################

`define MIPS_XLEN 32          // data and address width.
`define MIPS_NREGS 32         // architectural registers.
`define MIPS_RADDRW 5         // register index width.

// ############################################################
// reset values.
// ############################################################

// pc+4 held in IF/ID until the first capture.
`define MIPS_RESET_PCPLUS4 32'h0000_0000

`endif

/* mipsDecode.f */
+incdir+include
src/mipsPkg.sv
src/fetchIf.sv
src/ifIdReg.sv
src/regFile.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/decodeStage.sv
src/mipsDecodeTop.sv
sim/tbMipsDecode.sv

/* sim/tbMipsDecode.sv */
`timescale 1ns/1ps
`include "mipsDecode_cfg.svh"

module tbMipsDecode;
	import mipsPkg::*;

	logic clk = 1'b0;
	logic arstN;
	logic fetchValid, fetchExc, stall, flush, wbEn;
	word_t fetchInstr, fetchPcPlus4, wbData;
	regAddr_t wbAddr;
	logic decValid, regWrite, memRead, memWrite, aluSrcImm, regDst;
	logic branch, jump, link, branchTaken, excReserved, excFetch;
	instrOp_t decOp;
	aluFunc_t aluFunc;
	regAddr_t rs, rt, rd;
	logic [4:0] shamt;
	word_t extImm, srcA, srcB, pcPlus4, pcBranch, pcJump;

	int seed = 71;

	// shadow IF/ID register and register file.
	logic mValid, mExc;
	logic [31:0] mInstr, mPc;
	logic [31:0] mRegs [32];

	logic [5:0] opList [24] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
		6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
		6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
	logic [5:0] fnList [20] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
		6'h10, 6'h12, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	logic [4:0] riList [4] = '{5'h00, 5'h01, 5'h10, 5'h11};

	mipsDecodeTop dut (.*);

	always #4 clk = ~clk;

	// ############################################################
	// reference decode.
	// ############################################################

	function automatic instrOp_t predictOp(input logic [31:0] w);
		instrOp_t r;
		r = RESERVED;
		case (w[31:26])
			6'h00: begin
				case (w[5:0])
					6'h20: r = ADD;
					6'h21: r = ADDU;
					6'h22: r = SUB;
					6'h23: r = SUBU;
					6'h24: r = AND;
					6'h25: r = OR;
					6'h26: r = XOR;
					6'h27: r = NOR;
					6'h2a: r = SLT;
					6'h2b: r = SLTU;
					6'h00: r = SLL;
					6'h02: r = SRL;
					6'h03: r = SRA;
					6'h04: r = SLLV;
					6'h06: r = SRLV;
					6'h07: r = SRAV;
					6'h08: r = JR;
					6'h09: r = JALR;
					6'h10: r = MFHI;
					6'h12: r = MFLO;
					default: r = RESERVED;
				endcase
			end
			6'h01: begin
				case (w[20:16])
					5'h00: r = BLTZ;
					5'h01: r = BGEZ;
					5'h10: r = BLTZAL;
					5'h11: r = BGEZAL;
					default: r = RESERVED;
				endcase
			end
			6'h02: r = J;
			6'h03: r = JAL;
			6'h04: r = BEQ;
			6'h05: r = BNE;
			6'h06: r = BLEZ;
			6'h07: r = BGTZ;
			6'h08: r = ADDI;
			6'h09: r = ADDIU;
			6'h0a: r = SLTI;
			6'h0b: r = SLTIU;
			6'h0c: r = ANDI;
			6'h0d: r = ORI;
			6'h0e: r = XORI;
			6'h0f: r = LUI;
			6'h20: r = LB;
			6'h21: r = LH;
			6'h23: r = LW;
			6'h24: r = LBU;
			6'h25: r = LHU;
			6'h28: r = SB;
			6'h29: r = SH;
			6'h2b: r = SW;
			default: r = RESERVED;
		endcase
		return r;
	endfunction

	function automatic aluFunc_t predictAlu(input instrOp_t o);
		if (o inside {ADD, ADDU, ADDI, ADDIU, LB, LBU, LH, LHU, LW, SB, SH, SW})
			return ALU_ADD;
		if (o inside {SUB, SUBU})
			return ALU_SUB;
		if (o inside {SLT, SLTI})
			return ALU_SLT;
		if (o inside {SLTU, SLTIU})
			return ALU_SLTU;
		if (o inside {AND, ANDI})
			return ALU_AND;
		if (o inside {OR, ORI})
			return ALU_OR;
		if (o inside {XOR, XORI})
			return ALU_XOR;
		if (o == NOR)
			return ALU_NOR;
		if (o inside {SLL, SLLV})
			return ALU_SLL;
		if (o inside {SRL, SRLV})
			return ALU_SRL;
		if (o inside {SRA, SRAV})
			return ALU_SRA;
		if (o == LUI)
			return ALU_LUI;
		return ALU_PASS;
	endfunction

	// ############################################################
	// checking and stimulus.
	// ############################################################

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic failTimeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped after a timeout");
	endtask

	task automatic resetModel();
		mValid = 1'b0;
		mInstr = '0;
		mPc = `MIPS_RESET_PCPLUS4;
		mExc = 1'b0;
		for (int i = 0; i < 32; i++) begin
			mRegs[i] = '0;
		end
	endtask

	// inputs still hold what the DUT sampled at this edge.
	task automatic updateModel();
		if (flush) begin
			mValid = 1'b0;    // flush beats stall.
		end else if (!stall) begin
			mValid = fetchValid;
			mInstr = fetchInstr;
			mPc = fetchPcPlus4;
			mExc = fetchExc;
		end
		if (wbEn && (wbAddr != 5'd0))
			mRegs[wbAddr] = wbData;
	endtask

	task automatic checkOutputs();
		instrOp_t eOp;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] eImm;
		logic v, aluR, aluI, load, store, br, jmp, lnk, taken;
		eOp = predictOp(mInstr);
		v = mValid;
		a = mRegs[mInstr[25:21]];
		b = mRegs[mInstr[20:16]];
		aluR = eOp inside {ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
			SLL, SRL, SRA, SLLV, SRLV, SRAV};
		aluI = eOp inside {ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI};
		load = eOp inside {LB, LBU, LH, LHU, LW};
		store = eOp inside {SB, SH, SW};
		br = eOp inside {BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ, BLTZAL, BGEZAL};
		jmp = eOp inside {J, JAL, JR, JALR};
		lnk = eOp inside {JAL, JALR, BLTZAL, BGEZAL};
		if (eOp inside {ANDI, ORI, XORI})
			eImm = {16'h0000, mInstr[15:0]};
		else
			eImm = {{16{mInstr[15]}}, mInstr[15:0]};
		case (eOp)
			BEQ: taken = (a == b);
			BNE: taken = (a != b);
			BLEZ: taken = a[31] || (a == 32'd0);
			BGTZ: taken = !a[31] && (a != 32'd0);
			BLTZ, BLTZAL: taken = a[31];
			BGEZ, BGEZAL: taken = !a[31];
			default: taken = 1'b0;
		endcase
		checkEq("decValid", 32'(decValid), 32'(v));
		checkEq("decOp", 32'(decOp), 32'(eOp));
		checkEq("aluFunc", 32'(aluFunc), 32'(predictAlu(eOp)));
		checkEq("regWrite", 32'(regWrite),
			32'(v && (aluR || aluI || load || lnk || (eOp inside {MFHI, MFLO}))));
		checkEq("memRead", 32'(memRead), 32'(v && load));
		checkEq("memWrite", 32'(memWrite), 32'(v && store));
		checkEq("aluSrcImm", 32'(aluSrcImm), 32'(aluI || load || store));
		checkEq("regDst", 32'(regDst), 32'((mInstr[31:26] == 6'h00) && (eOp != RESERVED)));
		checkEq("branch", 32'(branch), 32'(v && br));
		checkEq("jump", 32'(jump), 32'(v && jmp));
		checkEq("link", 32'(link), 32'(v && lnk));
		checkEq("rs", 32'(rs), 32'(mInstr[25:21]));
		checkEq("rt", 32'(rt), 32'(mInstr[20:16]));
		checkEq("rd", 32'(rd), 32'((eOp inside {BLTZAL, BGEZAL, JAL}) ? 5'd31 : mInstr[15:11]));
		checkEq("shamt", 32'(shamt), 32'(mInstr[10:6]));
		checkEq("extImm", extImm, eImm);
		checkEq("srcA", srcA, a);
		checkEq("srcB", srcB, b);
		checkEq("pcPlus4", pcPlus4, mPc);
		checkEq("pcBranch", pcBranch, mPc + {eImm[29:0], 2'b00});
		checkEq("pcJump", pcJump, {mPc[31:28], mInstr[25:0], 2'b00});
		checkEq("branchTaken", 32'(branchTaken), 32'(v && taken));
		checkEq("excFetch", 32'(excFetch), 32'(v && mExc));
		checkEq("excReserved", 32'(excReserved), 32'(v && (eOp == RESERVED) && !mExc));
	endtask

	task automatic driveIdle();
		fetchValid <= 1'b0;
		fetchExc <= 1'b0;
		stall <= 1'b0;
		flush <= 1'b0;
		wbEn <= 1'b0;
	endtask

	task automatic driveRandom();
		logic [31:0] w;
		logic [31:0] d;
		w = $random(seed);
		// one word in eight stays raw and mostly lands on RESERVED.
		if (($random(seed) & 7) != 0) begin
			w[31:26] = opList[5'($unsigned($random(seed)) % 24)];
			if (w[31:26] == 6'h00)
				w[5:0] = fnList[5'($unsigned($random(seed)) % 20)];
			else if (w[31:26] == 6'h01)
				w[20:16] = riList[2'($random(seed))];
		end
		case (2'($random(seed)))
			2'd0: d = 32'd0;
			2'd1: d = 32'h8000_0000 | $random(seed);    // negative.
			2'd2: d = {28'd0, 4'($random(seed))};
			default: d = $random(seed);
		endcase
		fetchInstr <= w;
		fetchValid <= ($random(seed) & 7) != 0;
		fetchPcPlus4 <= $random(seed) & 32'hffff_fffc;
		fetchExc <= ($random(seed) & 7) == 0;
		stall <= ($random(seed) & 3) == 0;
		flush <= ($random(seed) & 7) == 0;
		wbEn <= ($random(seed) & 1) == 1;
		wbAddr <= (($random(seed) & 3) == 0) ? mInstr[25:21] : 5'($random(seed));
		wbData <= d;
	endtask

	task automatic runCycle(input logic randomize);
		@(posedge clk);
		updateModel();
		if (randomize)
			driveRandom();
		else
			driveIdle();
		@(negedge clk);
		checkOutputs();
	endtask

	// ############################################################
	// main sequence.
	// ############################################################

	initial begin
		int waited;
		arstN = 1'b0;
		fetchValid = 1'b0;
		fetchInstr = '0;
		fetchPcPlus4 = '0;
		fetchExc = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		wbEn = 1'b0;
		wbAddr = '0;
		wbData = '0;
		resetModel();

		repeat (3) @(posedge clk);
		arstN <= 1'b1;

		waited = 0;
		while (decValid !== 1'b0 || pcPlus4 !== `MIPS_RESET_PCPLUS4) begin
			if (waited >= 20)
				failTimeout("the reset state");
			else begin
				@(negedge clk);
				waited++;
			end
		end
		@(negedge clk);
		checkOutputs();

		repeat (3000) runCycle(1'b1);

		// drain with idle inputs until IF/ID empties.
		runCycle(1'b0);
		waited = 0;
		while (decValid !== 1'b0) begin
			if (waited >= 8)
				failTimeout("the pipeline to drain");
			else begin
				runCycle(1'b0);
				waited++;
			end
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* src/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
	input mipsPkg::instrOp_t op,
	output mipsPkg::aluFunc_t aluFunc
);
	import mipsPkg::*;

	always_comb begin
		case (op)
			ADD, ADDU, ADDI, ADDIU,
			LB, LBU, LH, LHU, LW,
			SB, SH, SW: aluFunc = ALU_ADD;    // address calc shares the adder.
			SUB, SUBU: aluFunc = ALU_SUB;
			SLT, SLTI: aluFunc = ALU_SLT;
			SLTU, SLTIU: aluFunc = ALU_SLTU;
			AND, ANDI: aluFunc = ALU_AND;
			OR, ORI: aluFunc = ALU_OR;
			XOR, XORI: aluFunc = ALU_XOR;
			NOR: aluFunc = ALU_NOR;
			SLL, SLLV: aluFunc = ALU_SLL;
			SRL, SRLV: aluFunc = ALU_SRL;
			SRA, SRAV: aluFunc = ALU_SRA;
			LUI: aluFunc = ALU_LUI;
			default: aluFunc = ALU_PASS;
		endcase
	end

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps
`include "mipsDecode_cfg.svh"

module decodeStage (
	fetchIf.dst fd,
	output mipsPkg::regAddr_t rsAddr,
	output mipsPkg::regAddr_t rtAddr,
	input mipsPkg::word_t rsData,
	input mipsPkg::word_t rtData,
	output logic decValid,
	output mipsPkg::instrOp_t decOp,
	output mipsPkg::ctl_t ctl,
	output mipsPkg::regAddr_t rs,
	output mipsPkg::regAddr_t rt,
	output mipsPkg::regAddr_t rd,
	output logic [4:0] shamt,
	output mipsPkg::word_t extImm,
	output mipsPkg::word_t srcA,
	output mipsPkg::word_t srcB,
	output mipsPkg::word_t pcPlus4,
	output mipsPkg::word_t pcBranch,
	output mipsPkg::word_t pcJump,
	output logic branchTaken,
	output logic excReserved,
	output logic excFetch
);
	import mipsPkg::*;

	instrOp_t op;
	aluFunc_t aluFunc;
	logic reserved;
	logic isAluR, isAluI, isLoad, isStore, isBranch, isJump, isLink;
	logic zeroExt;
	logic [15:0] imm;
	logic taken;

	mainDecoder uMainDec (.instr(fd.instr), .op(op), .reserved(reserved));
	aluDecoder uAluDec (.op(op), .aluFunc(aluFunc));

	// ############################################################
	// fields, operands and targets.
	// ############################################################

	assign rsAddr = fd.instr.rFmt.rs;
	assign rtAddr = fd.instr.iFmt.rt;
	assign rs = rsAddr;
	assign rt = rtAddr;
	assign rd = (op inside {BLTZAL, BGEZAL, JAL}) ? 5'd31 : fd.instr.rFmt.rd;
	assign shamt = fd.instr.rFmt.shamt;
	assign srcA = rsData;
	assign srcB = rtData;

	assign imm = fd.instr.iFmt.imm;
	assign zeroExt = op inside {ANDI, ORI, XORI};    // logic immediates.
	assign extImm = zeroExt ? {{(`MIPS_XLEN-16){1'b0}}, imm} : {{(`MIPS_XLEN-16){imm[15]}}, imm};

	assign pcPlus4 = fd.pcPlus4;
	assign pcBranch = fd.pcPlus4 + {extImm[`MIPS_XLEN-3:0], 2'b00};
	assign pcJump = {fd.pcPlus4[`MIPS_XLEN-1:28], fd.instr.jFmt.target, 2'b00};

	// ############################################################
	// control.
	// ############################################################

	assign isAluR = op inside {ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		SLL, SRL, SRA, SLLV, SRLV, SRAV};
	assign isAluI = op inside {ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI};
	assign isLoad = op inside {LB, LBU, LH, LHU, LW};
	assign isStore = op inside {SB, SH, SW};
	assign isBranch = op inside {BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ, BLTZAL, BGEZAL};
	assign isJump = op inside {J, JAL, JR, JALR};
	assign isLink = op inside {JAL, JALR, BLTZAL, BGEZAL};

	always_comb begin
		case (op)
			BEQ: taken = (srcA == srcB);
			BNE: taken = (srcA != srcB);
			BLEZ: taken = srcA[`MIPS_XLEN-1] || (srcA == '0);
			BGTZ: taken = !srcA[`MIPS_XLEN-1] && (srcA != '0);
			BLTZ, BLTZAL: taken = srcA[`MIPS_XLEN-1];
			BGEZ, BGEZAL: taken = !srcA[`MIPS_XLEN-1];
			default: taken = 1'b0;
		endcase
	end

	assign decValid = fd.valid;
	assign decOp = op;

	assign ctl.regWrite = fd.valid && (isAluR || isAluI || isLoad || isLink ||
		(op inside {MFHI, MFLO}));
	assign ctl.memRead = fd.valid && isLoad;
	assign ctl.memWrite = fd.valid && isStore;
	assign ctl.aluSrcImm = isAluI || isLoad || isStore;
	assign ctl.regDst = isAluR || (op inside {JR, JALR, MFHI, MFLO});    // r-type.
	assign ctl.branch = fd.valid && isBranch;
	assign ctl.jump = fd.valid && isJump;
	assign ctl.link = fd.valid && isLink;
	assign ctl.aluFunc = aluFunc;

	assign branchTaken = fd.valid && taken;
	assign excFetch = fd.valid && fd.excFetch;
	// a fetch fault hides whatever the word decodes to.
	assign excReserved = fd.valid && reserved && !fd.excFetch;

endmodule

/* src/fetchIf.sv */
`timescale 1ns/1ps

// instruction bundle held in IF/ID, read by decode.
interface fetchIf;
	import mipsPkg::*;

	logic valid;
	instrWord_t instr;
	word_t pcPlus4;
	logic excFetch;    // fetch-side exception flag.

	modport src (
		output valid, instr, pcPlus4, excFetch
	);

	modport dst (
		input valid, instr, pcPlus4, excFetch
	);

endinterface

/* src/ifIdReg.sv */
`timescale 1ns/1ps
`include "mipsDecode_cfg.svh"

module ifIdReg (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input mipsPkg::word_t fetchInstr,
	input mipsPkg::word_t fetchPcPlus4,
	input logic fetchExc,
	input logic stall,
	input logic flush,
	fetchIf.src fd
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fd.valid <= 1'b0;
			fd.instr <= '0;
			fd.pcPlus4 <= `MIPS_RESET_PCPLUS4;
			fd.excFetch <= 1'b0;
		end else if (flush) begin
			fd.valid <= 1'b0;    // squash wins over hold.
		end else if (!stall) begin
			fd.valid <= fetchValid;
			fd.instr <= fetchInstr;
			fd.pcPlus4 <= fetchPcPlus4;
			fd.excFetch <= fetchExc;
		end
	end

endmodule

/* src/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder (
	input mipsPkg::instrWord_t instr,
	output mipsPkg::instrOp_t op,
	output logic reserved
);
	import mipsPkg::*;

	always_comb begin
		op = RESERVED;
		case (instr.rFmt.op)
			OPC_SPECIAL: begin
				case (instr.rFmt.funct)
					FN_ADD: op = ADD;
					FN_ADDU: op = ADDU;
					FN_SUB: op = SUB;
					FN_SUBU: op = SUBU;
					FN_AND: op = AND;
					FN_OR: op = OR;
					FN_XOR: op = XOR;
					FN_NOR: op = NOR;
					FN_SLT: op = SLT;
					FN_SLTU: op = SLTU;
					FN_SLL: op = SLL;
					FN_SRL: op = SRL;
					FN_SRA: op = SRA;
					FN_SLLV: op = SLLV;
					FN_SRLV: op = SRLV;
					FN_SRAV: op = SRAV;
					FN_JR: op = JR;
					FN_JALR: op = JALR;
					FN_MFHI: op = MFHI;
					FN_MFLO: op = MFLO;
					default: op = RESERVED;
				endcase
			end
			OPC_REGIMM: begin
				// rt picks the branch flavour.
				case (instr.iFmt.rt)
					RI_BLTZ: op = BLTZ;
					RI_BGEZ: op = BGEZ;
					RI_BLTZAL: op = BLTZAL;
					RI_BGEZAL: op = BGEZAL;
					default: op = RESERVED;
				endcase
			end
			OPC_J: op = J;
			OPC_JAL: op = JAL;
			OPC_BEQ: op = BEQ;
			OPC_BNE: op = BNE;
			OPC_BLEZ: op = BLEZ;
			OPC_BGTZ: op = BGTZ;
			OPC_ADDI: op = ADDI;
			OPC_ADDIU: op = ADDIU;
			OPC_SLTI: op = SLTI;
			OPC_SLTIU: op = SLTIU;
			OPC_ANDI: op = ANDI;
			OPC_ORI: op = ORI;
			OPC_XORI: op = XORI;
			OPC_LUI: op = LUI;
			OPC_LB: op = LB;
			OPC_LBU: op = LBU;
			OPC_LH: op = LH;
			OPC_LHU: op = LHU;
			OPC_LW: op = LW;
			OPC_SB: op = SB;
			OPC_SH: op = SH;
			OPC_SW: op = SW;
			default: op = RESERVED;
		endcase
	end

	assign reserved = (op == RESERVED);

endmodule

/* src/mipsDecodeTop.sv */
`timescale 1ns/1ps

module mipsDecodeTop (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input mipsPkg::word_t fetchInstr,
	input mipsPkg::word_t fetchPcPlus4,
	input logic fetchExc,
	input logic stall,
	input logic flush,
	input logic wbEn,
	input mipsPkg::regAddr_t wbAddr,
	input mipsPkg::word_t wbData,
	output logic decValid,
	output mipsPkg::instrOp_t decOp,
	output mipsPkg::aluFunc_t aluFunc,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic aluSrcImm,
	output logic regDst,
	output logic branch,
	output logic jump,
	output logic link,
	output mipsPkg::regAddr_t rs,
	output mipsPkg::regAddr_t rt,
	output mipsPkg::regAddr_t rd,
	output logic [4:0] shamt,
	output mipsPkg::word_t extImm,
	output mipsPkg::word_t srcA,
	output mipsPkg::word_t srcB,
	output mipsPkg::word_t pcPlus4,
	output mipsPkg::word_t pcBranch,
	output mipsPkg::word_t pcJump,
	output logic branchTaken,
	output logic excReserved,
	output logic excFetch
);
	import mipsPkg::*;

	regAddr_t rsAddr, rtAddr;
	word_t rsData, rtData;
	ctl_t ctl;

	fetchIf fdBus ();

	ifIdReg uIfId (
		.clk(clk), .arstN(arstN),
		.fetchValid(fetchValid), .fetchInstr(fetchInstr),
		.fetchPcPlus4(fetchPcPlus4), .fetchExc(fetchExc),
		.stall(stall), .flush(flush),
		.fd(fdBus.src)
	);

	regFile uRegFile (
		.clk(clk), .arstN(arstN),
		.rsAddr(rsAddr), .rtAddr(rtAddr),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	decodeStage uDecode (
		.fd(fdBus.dst),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
		.decValid(decValid), .decOp(decOp), .ctl(ctl),
		.rs(rs), .rt(rt), .rd(rd), .shamt(shamt),
		.extImm(extImm), .srcA(srcA), .srcB(srcB),
		.pcPlus4(pcPlus4), .pcBranch(pcBranch), .pcJump(pcJump),
		.branchTaken(branchTaken), .excReserved(excReserved), .excFetch(excFetch)
	);

	// control struct out to plain pins.
	assign regWrite = ctl.regWrite;
	assign memRead = ctl.memRead;
	assign memWrite = ctl.memWrite;
	assign aluSrcImm = ctl.aluSrcImm;
	assign regDst = ctl.regDst;
	assign branch = ctl.branch;
	assign jump = ctl.jump;
	assign link = ctl.link;
	assign aluFunc = ctl.aluFunc;

endmodule

/* src/mipsPkg.sv */
`include "mipsDecode_cfg.svh"

package mipsPkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [`MIPS_RADDRW-1:0] regAddr_t;

	// ############################################################
	// primary opcodes, funct codes and REGIMM rt codes.
	// ############################################################

	localparam logic [5:0] OPC_SPECIAL = 6'h00, OPC_REGIMM = 6'h01;
	localparam logic [5:0] OPC_J = 6'h02, OPC_JAL = 6'h03;
	localparam logic [5:0] OPC_BEQ = 6'h04, OPC_BNE = 6'h05;
	localparam logic [5:0] OPC_BLEZ = 6'h06, OPC_BGTZ = 6'h07;
	localparam logic [5:0] OPC_ADDI = 6'h08, OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_SLTI = 6'h0a, OPC_SLTIU = 6'h0b;
	localparam logic [5:0] OPC_ANDI = 6'h0c, OPC_ORI = 6'h0d;
	localparam logic [5:0] OPC_XORI = 6'h0e, OPC_LUI = 6'h0f;
	localparam logic [5:0] OPC_LB = 6'h20, OPC_LH = 6'h21, OPC_LW = 6'h23;
	localparam logic [5:0] OPC_LBU = 6'h24, OPC_LHU = 6'h25;
	localparam logic [5:0] OPC_SB = 6'h28, OPC_SH = 6'h29, OPC_SW = 6'h2b;

	localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR = 6'h08, FN_JALR = 6'h09;
	localparam logic [5:0] FN_MFHI = 6'h10, FN_MFLO = 6'h12;
	localparam logic [5:0] FN_ADD = 6'h20, FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB = 6'h22, FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24, FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26, FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a, FN_SLTU = 6'h2b;

	localparam logic [4:0] RI_BLTZ = 5'h00, RI_BGEZ = 5'h01;
	localparam logic [4:0] RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11;

	// ############################################################
	// decoded instruction and alu function.
	// ############################################################

	typedef enum logic [5:0] {
		RESERVED,
		ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		SLL, SRL, SRA, SLLV, SRLV, SRAV, JR, JALR, MFHI, MFLO,
		ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LB, LBU, LH, LHU, LW, SB, SH, SW,
		BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ, BLTZAL, BGEZAL,
		J, JAL
	} instrOp_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS
	} aluFunc_t;

	// three views of one fetched word.
	typedef struct packed {
		logic [5:0] op;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	typedef struct packed {
		logic [5:0] op;
		regAddr_t rs;
		regAddr_t rt;
		logic [15:0] imm;
	} iFmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target;
	} jFmt_t;

	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
		jFmt_t jFmt;
	} instrWord_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluSrcImm;
		logic regDst;
		logic branch;
		logic jump;
		logic link;
		aluFunc_t aluFunc;
	} ctl_t;

endpackage

/* src/regFile.sv */
`timescale 1ns/1ps
`include "mipsDecode_cfg.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input mipsPkg::regAddr_t rsAddr,
	input mipsPkg::regAddr_t rtAddr,
	input logic wbEn,
	input mipsPkg::regAddr_t wbAddr,
	input mipsPkg::word_t wbData,
	output mipsPkg::word_t rsData,
	output mipsPkg::word_t rtData
);
	import mipsPkg::*;

	word_t regs [`MIPS_NREGS];

	// ############################################################
	// write port.
	// ############################################################

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn && (wbAddr != '0)) begin
			regs[wbAddr] <= wbData;    // $0 is never written.
		end
	end

	// read ports, no bypass from the write port.
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule
